// File: Bender.yml
package:
  name: mem_wb_backend

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_core_pkg.sv
      - verilog/pipe_seg_reg.sv
      - verilog/mem_access_stage.sv
      - verilog/writeback_stage.sv
      - verilog/gpr_file.sv
      - verilog/mem_wb_backend.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_mem_wb_backend.sv

// File: bench/backend_cases.txt
# kind stall flush_ex flush_mem pc rd alu_out store_data size [expected], one line per cycle
# Fields after kind are hex, size is funct3, expected is read back through rs1 on rb lines
alu  0 0 0 00001000 01 00000011 00000000 2
alu  0 0 0 00001004 02 deadbeef 00000000 2
alu  0 0 0 00001008 00 12345678 00000000 2
alu  0 0 0 0000100c 1f 80000001 00000000 2
idle 0 0 0 00000000 00 00000000 00000000 0
rb   0 0 0 00000000 01 00000000 00000000 0 00000011
rb   0 0 0 00000000 02 00000000 00000000 0 deadbeef
rb   0 0 0 00000000 00 00000000 00000000 0 00000000
rb   0 0 0 00000000 1f 00000000 00000000 0 80000001
# Stores of every width, loads of every size, a load right after its store
st   0 0 0 00001010 00 00000040 8899aabb 2
ld   0 0 0 00001014 03 00000040 00000000 2
st   0 0 0 00001018 00 00000043 000000f1 0
st   0 0 0 0000101c 00 00000040 00007e02 1
ld   0 0 0 00001020 04 00000043 00000000 0
ld   0 0 0 00001024 05 00000043 00000000 4
ld   0 0 0 00001028 06 00000042 00000000 1
ld   0 0 0 0000102c 07 00000042 00000000 5
ld   0 0 0 00001030 08 00000040 00000000 1
ld   0 0 0 00001034 09 00000041 00000000 0
ld   0 0 0 00001038 0a 00000040 00000000 2
stx  0 0 0 0000103c 00 00000080 00000000 2
ld   0 0 0 00001040 0b 00000080 00000000 2
idle 0 0 0 00000000 00 00000000 00000000 0
rb   0 0 0 00000000 03 00000000 00000000 0 8899aabb
rb   0 0 0 00000000 04 00000000 00000000 0 fffffff1
rb   0 0 0 00000000 0b 00000000 00000000 0
# Three stall cycles with two instructions in flight
alu  0 0 0 00001100 0c 0000000c 00000000 2
alu  0 0 0 00001104 0d 0000000d 00000000 2
idle 1 0 0 00000000 00 00000000 00000000 0
idle 1 0 0 00000000 00 00000000 00000000 0
idle 1 0 0 00000000 00 00000000 00000000 0
idle 0 0 0 00000000 00 00000000 00000000 0
idle 0 0 0 00000000 00 00000000 00000000 0
rb   0 0 0 00000000 0c 00000000 00000000 0 0000000c
rb   0 0 0 00000000 0d 00000000 00000000 0 0000000d
# flush_mem alone drops the instruction, under stall it drops nothing
alu  0 0 0 00001200 0e 000000ee 00000000 2
idle 0 0 1 00000000 00 00000000 00000000 0
alu  0 0 0 00001204 0f 000000ff 00000000 2
idle 1 0 1 00000000 00 00000000 00000000 0
idle 0 0 0 00000000 00 00000000 00000000 0
idle 0 0 0 00000000 00 00000000 00000000 0
rb   0 0 0 00000000 0e 00000000 00000000 0 00000000
rb   0 0 0 00000000 0f 00000000 00000000 0 000000ff
# flush_ex cancels the second store
st   0 0 0 00001300 00 00000100 11111111 2
st   0 1 0 00001304 00 00000100 22222222 2
ld   0 0 0 00001308 10 00000100 00000000 2
idle 0 0 0 00000000 00 00000000 00000000 0
idle 0 0 0 00000000 00 00000000 00000000 0
rb   0 0 0 00000000 10 00000000 00000000 0 11111111
halt 0 0 0 00001400 00 00000000 00000000 2

// File: bench/tb_mem_wb_backend.sv
// Backend testbench

`include "rv_core_cfg.svh"

module tb_mem_wb_backend;

        import rv_core_pkg::*;

        localparam int addr_w = $clog2(`DMEM_WORDS);

        logic        clk;
        logic        rst;
        logic        ex_valid;
        logic [31:0] ex_pc;
        logic [31:0] ex_inst;
        logic [31:0] ex_alu_out;
        logic [31:0] ex_store_data;
        logic        ex_mem_read;
        logic        ex_mem_write;
        mem_size_t   ex_mem_size;
        logic        ex_write_gpr;
        logic [4:0]  ex_rd;
        logic        ex_halt;
        logic        stall;
        logic        flush_ex;
        logic        flush_mem;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic        commit;
        logic [31:0] commit_pc;
        logic [31:0] commit_inst;
        logic        wb_we;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        logic        halt;

        // Reference model, one slot per stage register.
        ex_mem_t     s0;
        ex_mem_t     s1;
        logic [31:0] s1_wdata;
        logic [31:0] model_mem [`DMEM_WORDS];
        logic [31:0] model_regs [32];

        logic [63:0] kind;
        logic [31:0] f_stall, f_fe, f_fm, f_pc, f_rd, f_alu, f_sdata, f_size, f_exp;
        integer      n_fields;
        integer      errors;
        integer      seed;
        integer      fd;
        integer      wait_cycles;
        string       line;
        logic        rb_pending;
        logic        rb_use_file;
        logic [31:0] rb_file_val;
        logic        halt_seen;

        mem_wb_backend i_mem_wb_backend (.*);

        always #5 clk = ~clk;

        function automatic logic [31:0] make_inst(input logic [6:0] opcode, input logic [4:0] rd,
                                                  input logic [2:0] f3);
                return {17'd0, f3, rd, opcode};
        endfunction

        // Pick the addressed lane and extend it as funct3 asks.
        function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] off,
                                                   input logic [2:0] size);
                logic [7:0]  b;
                logic [15:0] h;
                b = word[8*off +: 8];
                h = off[1] ? word[31:16] : word[15:0];
                case (size)
                        3'b000:  return {{24{b[7]}}, b};
                        3'b100:  return {24'd0, b};
                        3'b001:  return {{16{h[15]}}, h};
                        3'b101:  return {16'd0, h};
                        default: return word;
                endcase
        endfunction

        task automatic model_store(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [2:0] size);
                logic [addr_w-1:0] a;
                a = addr[addr_w+1:2];
                case (size)
                        3'b000, 3'b100: model_mem[a][8*addr[1:0] +: 8] = data[7:0];
                        3'b001, 3'b101: model_mem[a][16*addr[1] +: 16] = data[15:0];
                        default:        model_mem[a] = data;
                endcase
        endtask

        // *******************************************************************
        // Model update for the coming rising edge
        // *******************************************************************

        task automatic advance_model();
                ex_mem_t incoming;
                incoming = '{op_valid: ex_valid, pc: ex_pc, inst: ex_inst, alu_out: ex_alu_out,
                        store_data: ex_store_data, mem_read: ex_mem_read,
                        mem_write: ex_mem_write, mem_size: ex_mem_size,
                        write_gpr: ex_write_gpr, rd: ex_rd, halt: ex_halt};
                if (!stall) begin
                        if (s1.op_valid && s1.write_gpr && s1.rd != 5'd0) begin
                                model_regs[s1.rd] = s1_wdata;
                        end
                        if (flush_mem) begin
                                s1 = '0;
                        end else begin
                                s1 = s0;
                                s1_wdata = s0.mem_read ?
                                        load_value(model_mem[s0.alu_out[addr_w+1:2]],
                                                   s0.alu_out[1:0], s0.mem_size) : s0.alu_out;
                        end
                        if (s0.op_valid && s0.mem_write) begin
                                model_store(s0.alu_out, s0.store_data, s0.mem_size);
                        end
                        s0 = flush_ex ? '0 : incoming;
                end
        endtask

        task automatic apply_line();
                logic is_store;
                is_store      = (kind == "st") || (kind == "stx");
                stall         = f_stall[0];
                flush_ex      = f_fe[0];
                flush_mem     = f_fm[0];
                ex_valid      = is_store || (kind == "alu") || (kind == "ld") || (kind == "halt");
                ex_pc         = f_pc;
                ex_alu_out    = f_alu;
                ex_store_data = (kind == "stx") ? $random(seed) : f_sdata;
                ex_mem_read   = (kind == "ld");
                ex_mem_write  = is_store;
                ex_mem_size   = mem_size_t'(f_size[2:0]);
                ex_write_gpr  = (kind == "alu") || (kind == "ld");
                ex_rd         = f_rd[4:0];
                ex_halt       = (kind == "halt");
                case (kind)
                        "alu":       ex_inst = make_inst(7'h13, f_rd[4:0], 3'b000);
                        "ld":        ex_inst = make_inst(7'h03, f_rd[4:0], f_size[2:0]);
                        "st", "stx": ex_inst = make_inst(7'h23, 5'd0, f_size[2:0]);
                        "halt":      ex_inst = 32'h0010_0073;
                        default:     ex_inst = `NOP;
                endcase
                rb_pending  = (kind == "rb");
                rb_use_file = (n_fields >= 10);
                rb_file_val = f_exp;
                if (kind == "rb") begin
                        rs1_addr = f_rd[4:0];
                        rs2_addr = ~f_rd[4:0];
                end
        endtask

        // *******************************************************************
        // Output checks at the falling edge
        // *******************************************************************

        task automatic check_outputs();
                logic        exp_commit;
                logic        exp_we;
                logic        exp_halt;
                logic [31:0] rb_exp;
                logic [31:0] rb_exp_b;
                exp_commit = s1.op_valid && !stall;
                exp_we     = exp_commit && s1.write_gpr;
                exp_halt   = exp_commit && s1.halt;
                rb_exp     = rb_use_file ? rb_file_val : model_regs[rs1_addr];
                rb_exp_b   = model_regs[rs2_addr];
                if (commit !== exp_commit) begin
                        $display("CHECK FAILED commit expected %h actual %h", exp_commit, commit);
                        errors++;
                end
                if (wb_we !== exp_we) begin
                        $display("CHECK FAILED wb_we expected %h actual %h", exp_we, wb_we);
                        errors++;
                end
                if (halt !== exp_halt) begin
                        $display("CHECK FAILED halt expected %h actual %h", exp_halt, halt);
                        errors++;
                end
                if (exp_commit && commit_pc !== s1.pc) begin
                        $display("CHECK FAILED commit_pc expected %h actual %h", s1.pc, commit_pc);
                        errors++;
                end
                if (exp_commit && commit_inst !== s1.inst) begin
                        $display("CHECK FAILED commit_inst expected %h actual %h",
                                 s1.inst, commit_inst);
                        errors++;
                end
                if (exp_we && wb_rd !== s1.rd) begin
                        $display("CHECK FAILED wb_rd expected %h actual %h", s1.rd, wb_rd);
                        errors++;
                end
                if (exp_we && wb_data !== s1_wdata) begin
                        $display("CHECK FAILED wb_data expected %h actual %h", s1_wdata, wb_data);
                        errors++;
                end
                if (rb_pending && rs1_data !== rb_exp) begin
                        $display("CHECK FAILED rs1_data expected %h actual %h", rb_exp, rs1_data);
                        errors++;
                end
                if (rb_pending && rs2_data !== rb_exp_b) begin
                        $display("CHECK FAILED rs2_data expected %h actual %h",
                                 rb_exp_b, rs2_data);
                        errors++;
                end
                if (halt === 1'b1) begin
                        halt_seen = 1'b1;
                end
        endtask

        task automatic step_cycle();
                @(negedge clk);
                check_outputs();
                apply_line();
                advance_model();
        endtask

        // One cycle of fixed stimulus.
        task automatic directed_cycle(input logic [63:0] k, input logic s, input logic fm,
                                      input logic [4:0] rd, input logic [31:0] alu);
                kind     = k;
                f_stall  = {31'd0, s};
                f_fe     = 32'd0;
                f_fm     = {31'd0, fm};
                f_pc     = 32'h0000_1500;
                f_rd     = {27'd0, rd};
                f_alu    = alu;
                f_sdata  = 32'd0;
                f_size   = 32'd2;
                n_fields = 0;
                step_cycle();
        endtask

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                seed = 32'h16efadee;
                errors = 0;
                halt_seen = 1'b0;
                s0 = '0;
                s1 = '0;
                s1_wdata = 32'd0;
                for (int i = 0; i < 32; i++) begin
                        model_regs[i] = 32'd0;
                end
                kind = "idle";
                {f_stall, f_fe, f_fm, f_pc, f_rd, f_alu, f_sdata, f_size, f_exp} = '0;
                n_fields = 0;
                rs1_addr = 5'd0;
                rs2_addr = 5'd0;
                apply_line();
                repeat (8) @(negedge clk);
                rst = 1'b0;

                // A stall that meets flush_mem keeps the instruction in MEM/WB.
                directed_cycle("alu", 1'b0, 1'b0, 5'h11, 32'h0000_0a11);
                directed_cycle("idle", 1'b0, 1'b0, 5'h00, 32'd0);
                directed_cycle("idle", 1'b1, 1'b1, 5'h00, 32'd0);
                directed_cycle("idle", 1'b0, 1'b0, 5'h00, 32'd0);
                directed_cycle("rb", 1'b0, 1'b0, 5'h11, 32'd0);
                directed_cycle("idle", 1'b0, 1'b0, 5'h00, 32'd0);

                fd = $fopen("bench/backend_cases.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the cases file bench/backend_cases.txt");
                        errors++;
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                                        n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                                                kind, f_stall, f_fe, f_fm, f_pc, f_rd, f_alu,
                                                f_sdata, f_size, f_exp);
                                        step_cycle();
                                end
                        end
                        $fclose(fd);

                        // Let the pipe drain until the halt instruction commits.
                        kind = "idle";
                        {f_stall, f_fe, f_fm} = '0;
                        n_fields = 0;
                        wait_cycles = 0;
                        while (!halt_seen && wait_cycles < 20) begin
                                step_cycle();
                                wait_cycles++;
                        end
                        if (!halt_seen) begin
                                $display("Timed out waiting for the halt instruction to commit");
                                errors++;
                        end
                end

                $display("Errors: %0d", errors);
                if (errors == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

// File: src.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/pipe_seg_reg.sv
verilog/mem_access_stage.sv
verilog/writeback_stage.sv
verilog/gpr_file.sv
verilog/mem_wb_backend.sv
bench/tb_mem_wb_backend.sv

// File: verilog/gpr_file.sv
// General purpose register file

module gpr_file (
        input  logic        clk,
        input  logic        rst,
        input  logic        we,
        input  logic [4:0]  waddr,
        input  logic [31:0] wdata,
        input  logic [4:0]  raddr_a,
        input  logic [4:0]  raddr_b,
        output logic [31:0] rdata_a,
        output logic [31:0] rdata_b
);

        // x0 has no storage.
        logic [31:0] regs [1:31];

        // *******************************************************************
        // Write port
        // *******************************************************************

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= 32'd0;
                        end
                end else if (we && (waddr != 5'd0)) begin
                        regs[waddr] <= wdata;
                end
        end

        // *******************************************************************
        // Read ports
        // *******************************************************************

        assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
        assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

// File: verilog/mem_access_stage.sv
// Memory access stage

`include "rv_core_cfg.svh"

module mem_access_stage (
        input  logic                clk,
        input  logic                stall,
        input  rv_core_pkg::ex_mem_t ex_mem,
        output rv_core_pkg::mem_wb_t mem_wb
);

        import rv_core_pkg::*;

        localparam int addr_w = $clog2(`DMEM_WORDS);

        logic [31:0]       dmem [`DMEM_WORDS];
        logic [addr_w-1:0] word_addr;
        logic [1:0]        byte_off;
        logic [3:0]        byte_en;
        logic [31:0]       store_word;
        logic              store_en;
        logic [31:0]       read_word;
        logic [31:0]       lane_data;
        logic [31:0]       load_data;

        assign word_addr = ex_mem.alu_out[addr_w+1:2];
        assign byte_off  = ex_mem.alu_out[1:0];
        assign store_en  = ex_mem.op_valid && ex_mem.mem_write && !stall;

        // *******************************************************************
        // Store path
        // *******************************************************************

        // Replicate the store data so every lane sees its own bytes.
        always_comb begin
                case (ex_mem.mem_size)
                        MEM_B, MEM_BU: begin
                                byte_en    = 4'b0001 << byte_off;
                                store_word = {4{ex_mem.store_data[7:0]}};
                        end
                        MEM_H, MEM_HU: begin
                                byte_en    = 4'b0011 << {byte_off[1], 1'b0};
                                store_word = {2{ex_mem.store_data[15:0]}};
                        end
                        default: begin
                                byte_en    = 4'b1111;
                                store_word = ex_mem.store_data;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (store_en) begin
                        for (int i = 0; i < 4; i++) begin
                                if (byte_en[i]) begin
                                        dmem[word_addr][8*i +: 8] <= store_word[8*i +: 8];
                                end
                        end
                end
        end

        // *******************************************************************
        // Load path
        // *******************************************************************

        assign read_word = dmem[word_addr];
        assign lane_data = read_word >> {byte_off, 3'b000};

        always_comb begin
                case (ex_mem.mem_size)
                        MEM_B:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
                        MEM_BU:  load_data = {24'd0, lane_data[7:0]};
                        MEM_H:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
                        MEM_HU:  load_data = {16'd0, lane_data[15:0]};
                        default: load_data = read_word;
                endcase
        end

        // Pass the rest of the instruction on to writeback.
        always_comb begin
                mem_wb.op_valid   = ex_mem.op_valid;
                mem_wb.pc         = ex_mem.pc;
                mem_wb.inst       = ex_mem.inst;
                mem_wb.alu_out    = ex_mem.alu_out;
                mem_wb.rdata      = load_data;
                mem_wb.write_gpr  = ex_mem.write_gpr;
                mem_wb.mem_to_reg = ex_mem.mem_read;
                mem_wb.rd         = ex_mem.rd;
                mem_wb.halt       = ex_mem.halt;
        end

endmodule

// File: verilog/mem_wb_backend.sv
// Memory and writeback backend

`include "rv_core_cfg.svh"

module mem_wb_backend (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   ex_valid,
        input  logic [31:0]            ex_pc,
        input  logic [31:0]            ex_inst,
        input  logic [31:0]            ex_alu_out,
        input  logic [31:0]            ex_store_data,
        input  logic                   ex_mem_read,
        input  logic                   ex_mem_write,
        input  rv_core_pkg::mem_size_t ex_mem_size,
        input  logic                   ex_write_gpr,
        input  logic [4:0]             ex_rd,
        input  logic                   ex_halt,
        input  logic                   stall,
        input  logic                   flush_ex,
        input  logic                   flush_mem,
        input  logic [4:0]             rs1_addr,
        input  logic [4:0]             rs2_addr,
        output logic [31:0]            rs1_data,
        output logic [31:0]            rs2_data,
        output logic                   commit,
        output logic [31:0]            commit_pc,
        output logic [31:0]            commit_inst,
        output logic                   wb_we,
        output logic [4:0]             wb_rd,
        output logic [31:0]            wb_data,
        output logic                   halt
);

        import rv_core_pkg::*;

        localparam ex_mem_t ex_mem_bubble = '{
                op_valid: 1'b0, pc: `PC_RST, inst: `NOP, alu_out: 32'd0,
                store_data: 32'd0, mem_read: 1'b0, mem_write: 1'b0,
                mem_size: MEM_W, write_gpr: 1'b0, rd: 5'd0, halt: 1'b0
        };

        localparam mem_wb_t mem_wb_bubble = '{
                op_valid: 1'b0, pc: `PC_RST, inst: `NOP, alu_out: 32'd0,
                rdata: 32'd0, write_gpr: 1'b0, mem_to_reg: 1'b0, rd: 5'd0,
                halt: 1'b0
        };

        ex_mem_t ex_mem_d;
        ex_mem_t ex_mem_q;
        mem_wb_t mem_wb_d;
        mem_wb_t mem_wb_q;

        assign ex_mem_d = '{
                op_valid: ex_valid, pc: ex_pc, inst: ex_inst, alu_out: ex_alu_out,
                store_data: ex_store_data, mem_read: ex_mem_read,
                mem_write: ex_mem_write, mem_size: ex_mem_size,
                write_gpr: ex_write_gpr, rd: ex_rd, halt: ex_halt
        };

        // *******************************************************************
        // Pipeline
        // *******************************************************************

        pipe_seg_reg #(
                .payload_t (ex_mem_t),
                .bubble    (ex_mem_bubble)
        ) i_ex_mem_reg (
                .clk   (clk),
                .rst   (rst),
                .stall (stall),
                .flush (flush_ex),
                .d     (ex_mem_d),
                .q     (ex_mem_q)
        );

        mem_access_stage i_mem_access_stage (
                .clk    (clk),
                .stall  (stall),
                .ex_mem (ex_mem_q),
                .mem_wb (mem_wb_d)
        );

        pipe_seg_reg #(
                .payload_t (mem_wb_t),
                .bubble    (mem_wb_bubble)
        ) i_mem_wb_reg (
                .clk   (clk),
                .rst   (rst),
                .stall (stall),
                .flush (flush_mem),
                .d     (mem_wb_d),
                .q     (mem_wb_q)
        );

        writeback_stage i_writeback_stage (
                .stall       (stall),
                .mem_wb      (mem_wb_q),
                .wb_we       (wb_we),
                .wb_rd       (wb_rd),
                .wb_data     (wb_data),
                .commit      (commit),
                .commit_pc   (commit_pc),
                .commit_inst (commit_inst),
                .halt        (halt)
        );

        gpr_file i_gpr_file (
                .clk     (clk),
                .rst     (rst),
                .we      (wb_we),
                .waddr   (wb_rd),
                .wdata   (wb_data),
                .raddr_a (rs1_addr),
                .raddr_b (rs2_addr),
                .rdata_a (rs1_data),
                .rdata_b (rs2_data)
        );

endmodule

// File: verilog/pipe_seg_reg.sv
// Pipeline segment register

module pipe_seg_reg #(
        parameter type      payload_t = logic [31:0],
        parameter payload_t bubble    = '0
) (
        input  logic     clk,
        input  logic     rst,
        input  logic     stall,
        input  logic     flush,
        input  payload_t d,
        output payload_t q
);

        // *******************************************************************
        // Segment update
        // *******************************************************************

        // A stall wins over a flush, so a flushed stage survives
        // until the stall is released.
        always_ff @(posedge clk) begin
                if (rst || (flush && !stall)) begin
                        q <= bubble;
                end else if (!stall) begin
                        q <= d;
                end
        end

endmodule

// File: verilog/rv_core_cfg.svh
// Core configuration defines

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// *******************************************************************
// Pipeline bubble contents
// *******************************************************************

// PC carried by a bubble.
`define PC_RST 32'h8000_0000

// addi x0, x0, 0.
`define NOP 32'h0000_0013

// *******************************************************************
// Data memory
// *******************************************************************

// Depth in 32-bit words.
`define DMEM_WORDS 256

`endif

// File: verilog/rv_core_pkg.sv
// RV32I core shared types

package rv_core_pkg;

        // Load/store width and signedness, same encoding as funct3.
        typedef enum logic [2:0] {
                MEM_B  = 3'b000,
                MEM_H  = 3'b001,
                MEM_W  = 3'b010,
                MEM_BU = 3'b100,
                MEM_HU = 3'b101
        } mem_size_t;

        // *******************************************************************
        // Stage register payloads
        // *******************************************************************

        typedef struct packed {
                logic        op_valid;
                logic [31:0] pc;
                logic [31:0] inst;
                logic [31:0] alu_out;
                logic [31:0] store_data;
                logic        mem_read;
                logic        mem_write;
                mem_size_t   mem_size;
                logic        write_gpr;
                logic [4:0]  rd;
                logic        halt;
        } ex_mem_t;

        typedef struct packed {
                logic        op_valid;
                logic [31:0] pc;
                logic [31:0] inst;
                logic [31:0] alu_out;
                logic [31:0] rdata;
                logic        write_gpr;
                logic        mem_to_reg;
                logic [4:0]  rd;
                logic        halt;
        } mem_wb_t;

endpackage

// File: verilog/writeback_stage.sv
// Writeback stage

module writeback_stage (
        input  logic                 stall,
        input  rv_core_pkg::mem_wb_t mem_wb,
        output logic                 wb_we,
        output logic [4:0]           wb_rd,
        output logic [31:0]          wb_data,
        output logic                 commit,
        output logic [31:0]          commit_pc,
        output logic [31:0]          commit_inst,
        output logic                 halt
);

        // *******************************************************************
        // Result selection
        // *******************************************************************

        assign wb_data = mem_wb.mem_to_reg ? mem_wb.rdata : mem_wb.alu_out;
        assign wb_rd   = mem_wb.rd;

        // *******************************************************************
        // Commit
        // *******************************************************************

        // Nothing retires while the pipe is frozen, so a held
        // instruction commits once, on the cycle after the stall ends.
        assign commit      = mem_wb.op_valid && !stall;
        assign commit_pc   = mem_wb.pc;
        assign commit_inst = mem_wb.inst;

        assign wb_we = commit && mem_wb.write_gpr;

        // Halt only with the instruction that carries it
        assign halt = commit && mem_wb.halt;

endmodule
